/* compile.f */
logic/mips_isa_pkg.sv
logic/mips_pipe_pkg.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/mem_stage.sv
logic/hazard_ctrl.sv
logic/naive_mips_core.sv
tb/tb_naive_mips_core.sv

/* Bender.yml */
package:
  name: naive_mips_core

sources:
  - logic/mips_isa_pkg.sv
  - logic/mips_pipe_pkg.sv
  - logic/fetch_unit.sv
  - logic/decode_unit.sv
  - logic/execute_unit.sv
  - logic/mem_stage.sv
  - logic/hazard_ctrl.sv
  - logic/naive_mips_core.sv
  - target: simulation
    files:
      - tb/tb_naive_mips_core.sv

/* tb/tb_naive_mips_core.sv */
`timescale 1ns/10ps

module tb_naive_mips_core;

    typedef struct packed {
        mips_isa_pkg::word_t addr;
        logic [3:0]          be;
        mips_isa_pkg::word_t data;
    } store_t;

    localparam int max_cycles = 3000;

    logic                     clk = 1'b0;
    logic                     rst_n;
    mips_pipe_pkg::ibus_req_t ibus_req;
    mips_isa_pkg::word_t      ibus_rddata;
    logic                     ibus_stall;
    mips_pipe_pkg::dbus_req_t dbus_req;
    mips_isa_pkg::word_t      dbus_rddata;
    logic                     dbus_stall;

    mips_isa_pkg::word_t      rom [64];
    mips_isa_pkg::word_t      ram [64];
    store_t                   expected [$];
    int                       store_count = 0;
    int                       cycles;
    logic [15:0]              lfsr = 16'd91;
    mips_pipe_pkg::ibus_req_t held_ibus;
    mips_pipe_pkg::dbus_req_t held_dbus;
    logic                     ibus_held = 1'b0;  // ibus request stalled last cycle
    logic                     dbus_held = 1'b0;

    naive_mips_core dut (
        .clk(clk), .rst_n(rst_n),
        .ibus_o(ibus_req), .ibus_rddata_i(ibus_rddata), .ibus_stall_i(ibus_stall),
        .dbus_o(dbus_req), .dbus_rddata_i(dbus_rddata), .dbus_stall_i(dbus_stall)
    );

    always #20 clk = ~clk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [69:0] exp,
                                   input logic [69:0] act);
        stop_run($sformatf("CHECK FAILED at %0d ns: %s expected 0x%0h, got 0x%0h",
                           $time, name, exp, act));
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic mips_isa_pkg::word_t r_format(input logic [5:0] fn,
            input mips_isa_pkg::reg_addr_t rs, input mips_isa_pkg::reg_addr_t rt,
            input mips_isa_pkg::reg_addr_t rd);
        return {mips_isa_pkg::opc_special, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic mips_isa_pkg::word_t i_format(input logic [5:0] opc,
            input mips_isa_pkg::reg_addr_t rs, input mips_isa_pkg::reg_addr_t rt,
            input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic mips_isa_pkg::word_t j_format(input logic [25:0] index);
        return {mips_isa_pkg::opc_j, index};
    endfunction

    // compares a completing store against the next entry in program order
    task automatic check_store();
        store_t exp;
        if (store_count >= expected.size()) begin
            stop_run($sformatf("unexpected store to 0x%0h after the last expected store",
                               dbus_req.addr));
        end else begin
            exp = expected[store_count];
            assert (dbus_req.addr === exp.addr) else
                report_mismatch("dbus_o.addr", exp.addr, dbus_req.addr);
            assert (dbus_req.byte_en === exp.be) else
                report_mismatch("dbus_o.byte_en", exp.be, dbus_req.byte_en);
            assert (dbus_req.wrdata === exp.data) else
                report_mismatch("dbus_o.wrdata", exp.data, dbus_req.wrdata);
            store_count++;
        end
    endtask

    // bus models drive stall levels and read data for the coming cycle
    always @(negedge clk) begin : bus_model
        logic b0, b1, istall, dstall;
        int   widx;
        int   lane;
        if (ibus_held) begin
            assert (ibus_req === held_ibus) else
                report_mismatch("ibus_o", held_ibus, ibus_req);
        end
        if (dbus_held) begin
            assert (dbus_req === held_dbus) else
                report_mismatch("dbus_o", held_dbus, dbus_req);
        end
        lfsr   = lfsr_next(lfsr);
        b0     = lfsr[0];
        lfsr   = lfsr_next(lfsr);
        b1     = lfsr[0];
        istall = b0 & b1;
        ibus_stall  = istall;
        ibus_rddata = istall ? 'x : rom[ibus_req.addr[7:2]];
        held_ibus   = ibus_req;
        ibus_held   = ibus_req.read && istall;

        dstall = 1'b0;
        if (dbus_req.read || dbus_req.write) begin
            lfsr   = lfsr_next(lfsr);
            b0     = lfsr[0];
            lfsr   = lfsr_next(lfsr);
            b1     = lfsr[0];
            dstall = b0 & b1;
        end
        widx        = dbus_req.addr[7:2];
        dbus_stall  = dstall;
        dbus_rddata = (dbus_req.read && !dstall) ? ram[widx] : 'x;
        if (dbus_req.write && !dstall) begin
            check_store();
            for (lane = 0; lane < 4; lane++) begin
                if (dbus_req.byte_en[lane])
                    ram[widx][8*lane +: 8] = dbus_req.wrdata[8*lane +: 8];
            end
        end
        held_dbus = dbus_req;
        dbus_held = (dbus_req.read || dbus_req.write) && dstall;
    end

    initial begin
        rst_n       = 1'b0;
        ibus_rddata = '0;
        ibus_stall  = 1'b0;
        dbus_rddata = '0;
        dbus_stall  = 1'b0;
        for (int i = 0; i < 64; i++) begin
            rom[i] = '0;                          // sll r0 acts as nop
            ram[i] = 32'h5a5a_0000 | (i << 2);
        end
        rom[0]  = i_format(mips_isa_pkg::opc_addiu, 0, 1, 16'd5);
        rom[1]  = i_format(mips_isa_pkg::opc_addiu, 0, 2, 16'd7);
        rom[2]  = r_format(mips_isa_pkg::fn_addu, 1, 2, 3);      // r3 = 12
        rom[3]  = i_format(mips_isa_pkg::opc_addiu, 3, 4, 16'd100);  // r4 = 112
        rom[4]  = r_format(mips_isa_pkg::fn_subu, 4, 2, 5);      // r5 = 105
        rom[5]  = r_format(mips_isa_pkg::fn_addu, 5, 3, 6);      // r6 = 117
        rom[6]  = i_format(mips_isa_pkg::opc_sw, 0, 6, 16'h0040);
        rom[7]  = i_format(mips_isa_pkg::opc_sw, 0, 5, 16'h0044);
        rom[8]  = i_format(mips_isa_pkg::opc_lw, 0, 7, 16'h0040);
        rom[9]  = r_format(mips_isa_pkg::fn_addu, 7, 6, 8);      // load-use gives r8 = 234
        rom[10] = i_format(mips_isa_pkg::opc_sw, 0, 8, 16'h0048);
        rom[11] = i_format(mips_isa_pkg::opc_beq, 5, 5, 16'd3);  // taken to word 15
        rom[12] = i_format(mips_isa_pkg::opc_addiu, 0, 9, 16'h0011);
        rom[13] = i_format(mips_isa_pkg::opc_sw, 0, 0, 16'h004c);
        rom[14] = i_format(mips_isa_pkg::opc_sw, 0, 1, 16'h004c);
        rom[15] = i_format(mips_isa_pkg::opc_sw, 0, 9, 16'h0050);
        rom[16] = i_format(mips_isa_pkg::opc_bne, 1, 1, 16'd2);  // not taken
        rom[17] = i_format(mips_isa_pkg::opc_addiu, 9, 9, 16'd1);
        rom[18] = i_format(mips_isa_pkg::opc_sw, 0, 9, 16'h0054);
        rom[19] = j_format(26'd22);
        rom[20] = i_format(mips_isa_pkg::opc_addiu, 9, 9, 16'd1);
        rom[21] = i_format(mips_isa_pkg::opc_sw, 0, 0, 16'h0058);
        rom[22] = i_format(mips_isa_pkg::opc_sw, 0, 9, 16'h005c);
        rom[23] = i_format(mips_isa_pkg::opc_lui, 0, 10, 16'h1234);
        rom[24] = i_format(mips_isa_pkg::opc_ori, 10, 10, 16'h80f0);  // r10 = 0x123480f0
        rom[25] = i_format(mips_isa_pkg::opc_sb, 0, 10, 16'h0061);
        rom[26] = i_format(mips_isa_pkg::opc_lb, 0, 11, 16'h0061);
        rom[27] = i_format(mips_isa_pkg::opc_lbu, 0, 12, 16'h0061);
        rom[28] = i_format(mips_isa_pkg::opc_sw, 0, 11, 16'h0064);
        rom[29] = i_format(mips_isa_pkg::opc_sw, 0, 12, 16'h0068);
        rom[30] = j_format(26'd30);                               // park here

        expected.push_back({32'h0000_0040, 4'hf, 32'd117});
        expected.push_back({32'h0000_0044, 4'hf, 32'd105});
        expected.push_back({32'h0000_0048, 4'hf, 32'd234});
        expected.push_back({32'h0000_0050, 4'hf, 32'h0000_0011});  // beq delay slot
        expected.push_back({32'h0000_0054, 4'hf, 32'h0000_0012});  // bne falls through
        expected.push_back({32'h0000_005c, 4'hf, 32'h0000_0013});  // j delay slot
        expected.push_back({32'h0000_0060, 4'b0010, 32'hf0f0_f0f0});
        expected.push_back({32'h0000_0064, 4'hf, 32'hffff_fff0});
        expected.push_back({32'h0000_0068, 4'hf, 32'h0000_00f0});

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        assert (ibus_req.addr === mips_isa_pkg::reset_vector) else
            report_mismatch("ibus_o.addr", mips_isa_pkg::reset_vector, ibus_req.addr);
        assert (ibus_req.read === 1'b1) else
            report_mismatch("ibus_o.read", 1'b1, ibus_req.read);
        assert (dbus_req.read === 1'b0) else
            report_mismatch("dbus_o.read", 1'b0, dbus_req.read);
        assert (dbus_req.write === 1'b0) else
            report_mismatch("dbus_o.write", 1'b0, dbus_req.write);

        cycles = 0;
        while (store_count < expected.size() && cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        if (store_count < expected.size()) begin
            stop_run($sformatf("timeout: only %0d of %0d stores after %0d cycles",
                               store_count, expected.size(), cycles));
        end else begin
            repeat (40) @(posedge clk);  // self jump so any further store is flagged
            $display("TEST OK");
            $finish;
        end
    end

endmodule

/* logic/naive_mips_core.sv */
`timescale 1ns/10ps

module naive_mips_core (
    input  logic                     clk,
    input  logic                     rst_n,
    output mips_pipe_pkg::ibus_req_t ibus_o,
    input  mips_isa_pkg::word_t      ibus_rddata_i,
    input  logic                     ibus_stall_i,
    output mips_pipe_pkg::dbus_req_t dbus_o,
    input  mips_isa_pkg::word_t      dbus_rddata_i,
    input  logic                     dbus_stall_i
);

    mips_pipe_pkg::stage_en_t en;
    mips_isa_pkg::word_t      if_pc, if_inst, branch_target;
    logic                     if_valid, branch_taken;
    mips_isa_pkg::reg_addr_t  rs, rt;
    mips_pipe_pkg::id_ex_t    id_ex;
    mips_pipe_pkg::ex_mm_t    ex_mm;
    mips_pipe_pkg::wb_port_t  ex_fwd, mm_fwd, wb;

    fetch_unit u_fetch (
        .clk(clk), .rst_n(rst_n), .en_i(en),
        .branch_taken_i(branch_taken), .branch_target_i(branch_target),
        .ibus_rddata_i(ibus_rddata_i), .ibus_o(ibus_o),
        .if_pc_o(if_pc), .if_inst_o(if_inst), .if_valid_o(if_valid)
    );

    decode_unit u_decode (
        .clk(clk), .rst_n(rst_n), .en_i(en),
        .if_pc_i(if_pc), .if_inst_i(if_inst), .if_valid_i(if_valid),
        .ex_fwd_i(ex_fwd), .mm_fwd_i(mm_fwd), .wb_i(wb),
        .rs_o(rs), .rt_o(rt),
        .branch_taken_o(branch_taken), .branch_target_o(branch_target),
        .id_ex_o(id_ex)
    );

    execute_unit u_execute (
        .clk(clk), .rst_n(rst_n), .en_i(en), .id_ex_i(id_ex),
        .ex_fwd_o(ex_fwd), .ex_mm_o(ex_mm)
    );

    mem_stage u_mem (
        .clk(clk), .rst_n(rst_n), .en_i(en), .ex_mm_i(ex_mm),
        .dbus_rddata_i(dbus_rddata_i), .dbus_o(dbus_o),
        .mm_fwd_o(mm_fwd), .wb_o(wb)
    );

    hazard_ctrl u_hazard (
        .ibus_stall_i(ibus_stall_i), .dbus_stall_i(dbus_stall_i),
        .rs_i(rs), .rt_i(rt), .ex_mm_i(ex_mm), .id_ex_i(id_ex),
        .en_o(en)
    );

endmodule

/* logic/hazard_ctrl.sv */
`timescale 1ns/10ps

module hazard_ctrl (
    input  logic                     ibus_stall_i,
    input  logic                     dbus_stall_i,
    input  mips_isa_pkg::reg_addr_t  rs_i,
    input  mips_isa_pkg::reg_addr_t  rt_i,
    input  mips_pipe_pkg::ex_mm_t    ex_mm_i,
    input  mips_pipe_pkg::id_ex_t    id_ex_i,
    output mips_pipe_pkg::stage_en_t en_o
);

    logic ex_hit, mm_hit;

    // a load result is only usable from wb
    assign ex_hit = id_ex_i.mem_op == mips_isa_pkg::mem_load && id_ex_i.dest != '0 &&
                    (id_ex_i.dest == rs_i || id_ex_i.dest == rt_i);
    assign mm_hit = ex_mm_i.mem_op == mips_isa_pkg::mem_load && ex_mm_i.dest != '0 &&
                    (ex_mm_i.dest == rs_i || ex_mm_i.dest == rt_i);

    always_comb begin
        if (dbus_stall_i)
            en_o = mips_pipe_pkg::en_freeze;
        else if (ex_hit || mm_hit || ibus_stall_i)
            en_o = mips_pipe_pkg::en_hold_front;
        else
            en_o = mips_pipe_pkg::en_run;
    end

endmodule

/* logic/mem_stage.sv */
`timescale 1ns/10ps

module mem_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mips_pipe_pkg::stage_en_t en_i,
    input  mips_pipe_pkg::ex_mm_t    ex_mm_i,
    input  mips_isa_pkg::word_t      dbus_rddata_i,
    output mips_pipe_pkg::dbus_req_t dbus_o,
    output mips_pipe_pkg::wb_port_t  mm_fwd_o,
    output mips_pipe_pkg::wb_port_t  wb_o
);

    logic                    is_byte;
    // mm/wb contents
    logic                    wb_we, wb_load;
    mips_isa_pkg::reg_addr_t wb_dest;
    mips_isa_pkg::word_t     wb_result, wb_rddata, lane;
    logic [1:0]              wb_addr_lo;
    mips_isa_pkg::mem_size_e wb_size;
    logic                    wb_unsigned;

    assign is_byte = (ex_mm_i.size == mips_isa_pkg::size_byte);

    assign dbus_o.addr    = {ex_mm_i.result[31:2], 2'b00};
    assign dbus_o.byte_en = is_byte ? 4'b0001 << ex_mm_i.result[1:0] : 4'b1111;
    assign dbus_o.read    = (ex_mm_i.mem_op == mips_isa_pkg::mem_load);
    assign dbus_o.write   = (ex_mm_i.mem_op == mips_isa_pkg::mem_store);
    assign dbus_o.wrdata  = is_byte ? {4{ex_mm_i.store_val[7:0]}} : ex_mm_i.store_val;

    assign mm_fwd_o.we    = ex_mm_i.reg_we && ex_mm_i.mem_op != mips_isa_pkg::mem_load;
    assign mm_fwd_o.dest  = ex_mm_i.dest;
    assign mm_fwd_o.value = ex_mm_i.result;

    // en_mmwb drops only on a data bus stall, which leaves a bubble behind
    always_ff @(posedge clk) begin
        if (!rst_n || !en_i.en_mmwb) begin
            wb_we   <= 1'b0;
            wb_load <= 1'b0;
        end else begin
            wb_we   <= ex_mm_i.reg_we;
            wb_load <= dbus_o.read;
        end
    end

    always_ff @(posedge clk) begin
        if (en_i.en_mmwb) begin
            wb_dest     <= ex_mm_i.dest;
            wb_result   <= ex_mm_i.result;
            wb_rddata   <= dbus_rddata_i;
            wb_addr_lo  <= ex_mm_i.result[1:0];
            wb_size     <= ex_mm_i.size;
            wb_unsigned <= ex_mm_i.is_unsigned;
        end
    end

    assign lane = wb_rddata >> {wb_addr_lo, 3'b000};

    always_comb begin
        wb_o.we   = wb_we;
        wb_o.dest = wb_dest;
        if (!wb_load)
            wb_o.value = wb_result;
        else if (wb_size == mips_isa_pkg::size_word)
            wb_o.value = wb_rddata;
        else if (wb_unsigned)
            wb_o.value = {24'b0, lane[7:0]};
        else
            wb_o.value = {{24{lane[7]}}, lane[7:0]};  // lb
    end

endmodule

/* logic/execute_unit.sv */
`timescale 1ns/10ps

module execute_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mips_pipe_pkg::stage_en_t en_i,
    input  mips_pipe_pkg::id_ex_t    id_ex_i,
    output mips_pipe_pkg::wb_port_t  ex_fwd_o,
    output mips_pipe_pkg::ex_mm_t    ex_mm_o
);

    mips_isa_pkg::word_t a, b, result;

    assign a = id_ex_i.op_a;
    assign b = id_ex_i.op_b;

    always_comb begin
        case (id_ex_i.alu_op)
            mips_isa_pkg::alu_add: result = a + b;  // also load/store address
            mips_isa_pkg::alu_sub: result = a - b;
            mips_isa_pkg::alu_and: result = a & b;
            mips_isa_pkg::alu_or:  result = a | b;
            mips_isa_pkg::alu_xor: result = a ^ b;
            mips_isa_pkg::alu_slt: result = {31'b0, $signed(a) < $signed(b)};
            mips_isa_pkg::alu_sll: result = b << a[4:0];
            default:               result = '0;
        endcase
    end

    // a load has no value yet so hazard_ctrl holds its consumer
    assign ex_fwd_o.we    = id_ex_i.reg_we && id_ex_i.mem_op != mips_isa_pkg::mem_load;
    assign ex_fwd_o.dest  = id_ex_i.dest;
    assign ex_fwd_o.value = result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mm_o.reg_we <= 1'b0;
            ex_mm_o.mem_op <= mips_isa_pkg::mem_none;
        end else if (en_i.en_exmm) begin
            ex_mm_o.result      <= result;
            ex_mm_o.store_val   <= id_ex_i.store_val;
            ex_mm_o.dest        <= id_ex_i.dest;
            ex_mm_o.reg_we      <= id_ex_i.reg_we;
            ex_mm_o.mem_op      <= id_ex_i.mem_op;
            ex_mm_o.size        <= id_ex_i.size;
            ex_mm_o.is_unsigned <= id_ex_i.is_unsigned;
        end
    end

endmodule

/* logic/decode_unit.sv */
`timescale 1ns/10ps

module decode_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mips_pipe_pkg::stage_en_t en_i,
    input  mips_isa_pkg::word_t      if_pc_i,
    input  mips_isa_pkg::word_t      if_inst_i,
    input  logic                     if_valid_i,
    input  mips_pipe_pkg::wb_port_t  ex_fwd_i,
    input  mips_pipe_pkg::wb_port_t  mm_fwd_i,
    input  mips_pipe_pkg::wb_port_t  wb_i,
    output mips_isa_pkg::reg_addr_t  rs_o,
    output mips_isa_pkg::reg_addr_t  rt_o,
    output logic                     branch_taken_o,
    output mips_isa_pkg::word_t      branch_target_o,
    output mips_pipe_pkg::id_ex_t    id_ex_o
);

    localparam int ext_w = mips_isa_pkg::word_w - mips_isa_pkg::imm_w;

    mips_isa_pkg::word_t       rf [32];
    mips_isa_pkg::word_t       inst, rs_val, rt_val, sext_imm, pc_plus4;
    mips_isa_pkg::reg_addr_t   rd;
    logic [5:0]                opc, fn;
    logic [mips_isa_pkg::imm_w-1:0] imm;
    mips_pipe_pkg::id_ex_t     d;

    assign inst     = if_valid_i ? if_inst_i : '0;  // empty slot decodes as sll r0
    assign opc      = inst[31:26];
    assign fn       = inst[5:0];
    assign rs_o     = inst[25:21];
    assign rt_o     = inst[20:16];
    assign rd       = inst[15:11];
    assign imm      = inst[15:0];
    assign sext_imm = {{ext_w{imm[mips_isa_pkg::imm_w-1]}}, imm};
    assign pc_plus4 = if_pc_i + 32'd4;

    always_ff @(posedge clk) begin
        if (wb_i.we && wb_i.dest != '0) begin
            rf[wb_i.dest] <= wb_i.value;
        end
    end

    // newest producer wins and r0 always reads zero
    function automatic mips_isa_pkg::word_t operand(input mips_isa_pkg::reg_addr_t idx);
        if (idx == '0) return '0;
        if (ex_fwd_i.we && ex_fwd_i.dest == idx) return ex_fwd_i.value;
        if (mm_fwd_i.we && mm_fwd_i.dest == idx) return mm_fwd_i.value;
        if (wb_i.we && wb_i.dest == idx) return wb_i.value;
        return rf[idx];
    endfunction

    always_comb begin
        rs_val = operand(rs_o);
        rt_val = operand(rt_o);
    end

    always_comb begin
        branch_taken_o  = 1'b0;
        branch_target_o = pc_plus4 + {sext_imm[29:0], 2'b00};
        case (opc)
            mips_isa_pkg::opc_beq: branch_taken_o = (rs_val == rt_val);
            mips_isa_pkg::opc_bne: branch_taken_o = (rs_val != rt_val);
            mips_isa_pkg::opc_j: begin
                branch_taken_o  = 1'b1;
                branch_target_o = {pc_plus4[31:28], inst[25:0], 2'b00};
            end
            default: ;
        endcase
    end

    always_comb begin
        d = '{alu_op: mips_isa_pkg::alu_add, op_a: rs_val, op_b: rt_val,
              store_val: rt_val, dest: rd, reg_we: 1'b0,
              mem_op: mips_isa_pkg::mem_none, size: mips_isa_pkg::size_word,
              is_unsigned: 1'b0};
        case (opc)
            mips_isa_pkg::opc_special: begin
                d.reg_we = 1'b1;
                case (fn)
                    mips_isa_pkg::fn_addu: d.alu_op = mips_isa_pkg::alu_add;
                    mips_isa_pkg::fn_subu: d.alu_op = mips_isa_pkg::alu_sub;
                    mips_isa_pkg::fn_and:  d.alu_op = mips_isa_pkg::alu_and;
                    mips_isa_pkg::fn_or:   d.alu_op = mips_isa_pkg::alu_or;
                    mips_isa_pkg::fn_xor:  d.alu_op = mips_isa_pkg::alu_xor;
                    mips_isa_pkg::fn_slt:  d.alu_op = mips_isa_pkg::alu_slt;
                    mips_isa_pkg::fn_sll: begin
                        d.alu_op = mips_isa_pkg::alu_sll;
                        d.op_a   = {27'b0, inst[10:6]};  // shamt
                    end
                    default: d.reg_we = 1'b0;
                endcase
            end
            mips_isa_pkg::opc_addiu: begin
                d.op_b   = sext_imm;
                d.dest   = rt_o;
                d.reg_we = 1'b1;
            end
            mips_isa_pkg::opc_ori: begin
                d.alu_op = mips_isa_pkg::alu_or;
                d.op_b   = {{ext_w{1'b0}}, imm};
                d.dest   = rt_o;
                d.reg_we = 1'b1;
            end
            mips_isa_pkg::opc_lui: begin
                d.op_a   = '0;
                d.op_b   = {imm, {ext_w{1'b0}}};
                d.dest   = rt_o;
                d.reg_we = 1'b1;
            end
            mips_isa_pkg::opc_lw, mips_isa_pkg::opc_lb, mips_isa_pkg::opc_lbu: begin
                d.op_b        = sext_imm;
                d.dest        = rt_o;
                d.reg_we      = 1'b1;
                d.mem_op      = mips_isa_pkg::mem_load;
                d.size        = (opc == mips_isa_pkg::opc_lw) ? mips_isa_pkg::size_word
                                                              : mips_isa_pkg::size_byte;
                d.is_unsigned = (opc == mips_isa_pkg::opc_lbu);
            end
            mips_isa_pkg::opc_sw, mips_isa_pkg::opc_sb: begin
                d.op_b   = sext_imm;
                d.mem_op = mips_isa_pkg::mem_store;
                d.size   = (opc == mips_isa_pkg::opc_sw) ? mips_isa_pkg::size_word
                                                         : mips_isa_pkg::size_byte;
            end
            default: ;  // unknown encodings fall through as no-ops
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || (!en_i.en_ifid && en_i.en_idex)) begin
            id_ex_o.reg_we <= 1'b0;
            id_ex_o.mem_op <= mips_isa_pkg::mem_none;
        end else if (en_i.en_idex) begin
            id_ex_o <= d;
        end
    end

endmodule

/* logic/fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mips_pipe_pkg::stage_en_t en_i,
    input  logic                    branch_taken_i,
    input  mips_isa_pkg::word_t     branch_target_i,
    input  mips_isa_pkg::word_t     ibus_rddata_i,
    output mips_pipe_pkg::ibus_req_t ibus_o,
    output mips_isa_pkg::word_t     if_pc_o,
    output mips_isa_pkg::word_t     if_inst_o,
    output logic                    if_valid_o
);

    mips_isa_pkg::word_t pc_q;

    // pc only moves on en_pc, so the bus address stays put across a stall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= mips_isa_pkg::reset_vector;
        end else if (en_i.en_pc) begin
            pc_q <= branch_taken_i ? branch_target_i : pc_q + 32'd4;
        end
    end

    assign ibus_o.addr = pc_q;
    assign ibus_o.read = 1'b1;

    // if/id holds while decode waits and replays the held instruction
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if_valid_o <= 1'b0;
        end else if (en_i.en_ifid) begin
            if_valid_o <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (en_i.en_ifid) begin
            if_pc_o   <= pc_q;
            if_inst_o <= ibus_rddata_i;  // data valid in the completing cycle
        end
    end

endmodule

/* logic/mips_pipe_pkg.sv */
package mips_pipe_pkg;

    typedef struct packed {
        mips_isa_pkg::word_t addr;
        logic                read;
    } ibus_req_t;

    typedef struct packed {
        mips_isa_pkg::word_t addr;      // word aligned
        logic [3:0]          byte_en;
        logic                read;
        logic                write;
        mips_isa_pkg::word_t wrdata;
    } dbus_req_t;

    typedef struct packed {
        mips_isa_pkg::alu_op_e   alu_op;
        mips_isa_pkg::word_t     op_a;
        mips_isa_pkg::word_t     op_b;
        mips_isa_pkg::word_t     store_val;
        mips_isa_pkg::reg_addr_t dest;
        logic                    reg_we;
        mips_isa_pkg::mem_op_e   mem_op;
        mips_isa_pkg::mem_size_e size;
        logic                    is_unsigned;
    } id_ex_t;

    typedef struct packed {
        mips_isa_pkg::word_t     result;    // alu result or memory address
        mips_isa_pkg::word_t     store_val;
        mips_isa_pkg::reg_addr_t dest;
        logic                    reg_we;
        mips_isa_pkg::mem_op_e   mem_op;
        mips_isa_pkg::mem_size_e size;
        logic                    is_unsigned;
    } ex_mm_t;

    typedef struct packed {
        logic                    we;
        mips_isa_pkg::reg_addr_t dest;
        mips_isa_pkg::word_t     value;
    } wb_port_t;

    typedef struct packed {
        logic en_pc;
        logic en_ifid;
        logic en_idex;
        logic en_exmm;
        logic en_mmwb;
    } stage_en_t;

    localparam stage_en_t en_run        = 5'b11111;
    localparam stage_en_t en_freeze     = 5'b00000;
    localparam stage_en_t en_hold_front = 5'b00111;  // pc and if/id wait while a bubble enters ex

endpackage

/* logic/mips_isa_pkg.sv */
package mips_isa_pkg;

    localparam int word_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int imm_w      = 16;

    localparam logic [word_w-1:0] reset_vector = 32'h0000_0000;

    // major opcodes in inst[31:26]
    localparam logic [5:0] opc_special = 6'h00;
    localparam logic [5:0] opc_j       = 6'h02;
    localparam logic [5:0] opc_beq     = 6'h04;
    localparam logic [5:0] opc_bne     = 6'h05;
    localparam logic [5:0] opc_addiu   = 6'h09;
    localparam logic [5:0] opc_ori     = 6'h0d;
    localparam logic [5:0] opc_lui     = 6'h0f;
    localparam logic [5:0] opc_lb      = 6'h20;
    localparam logic [5:0] opc_lw      = 6'h23;
    localparam logic [5:0] opc_lbu     = 6'h24;
    localparam logic [5:0] opc_sb      = 6'h28;
    localparam logic [5:0] opc_sw      = 6'h2b;

    // funct codes under opc_special
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_slt  = 6'h2a;

    typedef logic [word_w-1:0]     word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_sll
    } alu_op_e;
    typedef enum logic [1:0] {mem_none, mem_load, mem_store} mem_op_e;
    typedef enum logic {size_word, size_byte} mem_size_e;

endpackage
